//--- include/kcpu_defs.svh
`ifndef KCPU_DEFS_SVH
`define KCPU_DEFS_SVH

// program counter and address bus width.
`define KCPU_AW 16

// memory data width.
// the low byte carries pulled bytes and short offsets.
`define KCPU_DW 16

// push/pull postbyte width.
// one bit per stacked register.
`define KCPU_MASKW 8

`endif

//--- rtl/kcpu_pkg.sv
`default_nettype none

package kcpu_pkg;

    // bit positions inside the condition-code byte.
    typedef enum logic [2:0] {
        CC_C = 3'd0,
        CC_V = 3'd1,
        CC_Z = 3'd2,
        CC_N = 3'd3,
        CC_I = 3'd4,
        CC_H = 3'd5,
        CC_F = 3'd6,
        CC_E = 3'd7
    } cc_bit_e;

    // branch conditions in the order of the opcode low nibble.
    typedef enum logic [3:0] {
        BC_ALWAYS, BC_NEVER,
        BC_HI,     BC_LS,
        BC_CC,     BC_CS,
        BC_NE,     BC_EQ,
        BC_VC,     BC_VS,
        BC_PL,     BC_MI,
        BC_GE,     BC_LT,
        BC_GT,     BC_LE
    } bcond_e;

    // opcode tails selecting the LEA target.
    localparam logic [1:0] LEAX = 2'd0;
    localparam logic [1:0] LEAY = 2'd1;
    localparam logic [1:0] LEAU = 2'd2;
    localparam logic [1:0] LEAS = 2'd3;

endpackage

`default_nettype wire

//--- rtl/kcpu_branch.sv
`default_nettype none

module kcpu_branch (
    input  logic [7:0] op,
    input  logic [7:0] cc,
    output logic       branch
);

    logic            c;
    logic            v;
    logic            z;
    logic            n;
    logic            lt;
    kcpu_pkg::bcond_e cond;

    assign c = cc[kcpu_pkg::CC_C];
    assign v = cc[kcpu_pkg::CC_V];
    assign z = cc[kcpu_pkg::CC_Z];
    assign n = cc[kcpu_pkg::CC_N];

    // signed less-than.
    assign lt = n ^ v;

    assign cond = kcpu_pkg::bcond_e'(op[3:0]);

    always_comb begin
        case (cond)
            kcpu_pkg::BC_ALWAYS: branch = 1'b1;
            kcpu_pkg::BC_NEVER:  branch = 1'b0;
            // unsigned compares.
            kcpu_pkg::BC_HI:     branch = ~(c | z);
            kcpu_pkg::BC_LS:     branch = c | z;
            kcpu_pkg::BC_CC:     branch = ~c;
            kcpu_pkg::BC_CS:     branch = c;
            kcpu_pkg::BC_NE:     branch = ~z;
            kcpu_pkg::BC_EQ:     branch = z;
            kcpu_pkg::BC_VC:     branch = ~v;
            kcpu_pkg::BC_VS:     branch = v;
            kcpu_pkg::BC_PL:     branch = ~n;
            kcpu_pkg::BC_MI:     branch = n;
            // signed compares.
            kcpu_pkg::BC_GE:     branch = ~lt;
            kcpu_pkg::BC_LT:     branch = lt;
            kcpu_pkg::BC_GT:     branch = ~(z | lt);
            kcpu_pkg::BC_LE:     branch = z | lt;
            default:             branch = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/kcpu_pshpul.sv
`default_nettype none

`include "kcpu_defs.svh"

module kcpu_pshpul (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic                   mem_busy,
    input  logic                   psh_go,
    input  logic                   pul_go,
    input  logic                   psh_pc,
    input  logic [`KCPU_MASKW-1:0] postdata,
    output logic [`KCPU_MASKW-1:0] psh_sel,
    output logic                   hihalf,
    output logic                   pul_en,
    output logic                   psh_dec,
    output logic                   busy
);

    localparam int HALF = `KCPU_MASKW / 2;

    logic [`KCPU_MASKW-1:0] mask;
    logic [`KCPU_MASKW-1:0] cur_mask;
    logic [`KCPU_MASKW-1:0] bit_oh;
    logic                   dir_pull;
    logic                   cur_pull;
    logic                   second;
    logic                   start;
    logic                   step;
    logic                   wide;

    // start pulses are dropped while a transfer runs.
    assign start = (psh_go | pul_go) & ~busy;
    assign step  = start | (busy & ~mem_busy);

    assign cur_pull = start ? pul_go : dir_pull;
    assign cur_mask = start ? (postdata | {psh_pc, {(`KCPU_MASKW-1){1'b0}}}) : mask;

    // push takes the highest bit, pull the lowest.
    always_comb begin
        bit_oh = '0;
        if (cur_pull) begin
            for (int i = `KCPU_MASKW - 1; i >= 0; i--) begin
                if (cur_mask[i]) begin
                    bit_oh    = '0;
                    bit_oh[i] = 1'b1;
                end
            end
        end else begin
            for (int i = 0; i < `KCPU_MASKW; i++) begin
                if (cur_mask[i]) begin
                    bit_oh    = '0;
                    bit_oh[i] = 1'b1;
                end
            end
        end
    end

    // upper half of the mask holds the 16-bit registers.
    assign wide = |bit_oh[`KCPU_MASKW-1:HALF];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mask     <= '0;
            dir_pull <= 1'b0;
            second   <= 1'b0;
            busy     <= 1'b0;
            psh_sel  <= '0;
            psh_dec  <= 1'b0;
            pul_en   <= 1'b0;
            hihalf   <= 1'b0;
        end else if (cen && step) begin
            if (|cur_mask) begin
                busy     <= 1'b1;
                dir_pull <= cur_pull;
                psh_sel  <= bit_oh;
                psh_dec  <= ~cur_pull;
                pul_en   <= cur_pull;
                // push gives low then high, pull high then low.
                hihalf   <= wide & (cur_pull ^ second);
                if (wide && !second) begin
                    mask   <= cur_mask;
                    second <= 1'b1;
                end else begin
                    mask   <= cur_mask & ~bit_oh;
                    second <= 1'b0;
                end
            end else begin
                // nothing left, close the transfer.
                mask    <= '0;
                second  <= 1'b0;
                busy    <= 1'b0;
                psh_sel <= '0;
                psh_dec <= 1'b0;
                pul_en  <= 1'b0;
                hihalf  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/kcpu_pc.sv
`default_nettype none

`include "kcpu_defs.svh"

module kcpu_pc (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                pc_jmp,
    input  logic                pc_step,
    input  logic                pc_inc2,
    input  logic                up_pc,
    input  logic                set_pc_branch8,
    input  logic                set_pc_branch16,
    input  logic                branch_bnz,
    input  logic                branch,
    input  logic                up_pul_pc,
    input  logic                pul_en,
    input  logic                hihalf,
    input  logic                buserror,
    input  logic [7:0]          cc,
    input  logic [`KCPU_AW-1:0] mdata,
    input  logic [`KCPU_AW-1:0] idx_addr,
    output logic [`KCPU_AW-1:0] pc,
    output logic [`KCPU_AW-1:0] pcbad
);

    logic                sbranch;
    logic                lbranch;
    logic                bdone;
    logic [`KCPU_AW-1:0] offset8;
    logic [`KCPU_AW-1:0] pc_next;

    // short branch also covers the decrement-and-branch-if-not-zero case.
    assign sbranch = (set_pc_branch8 & branch) | (branch_bnz & ~cc[kcpu_pkg::CC_Z]);
    assign lbranch = set_pc_branch16 & branch;

    assign offset8 = {{(`KCPU_AW-8){mdata[7]}}, mdata[7:0]};

    always_comb begin
        pc_next = pc;
        if (pc_jmp) begin
            pc_next = idx_addr;
        end else if (pc_step) begin
            pc_next = pc + `KCPU_AW'd1;
        end else if (pc_inc2) begin
            pc_next = pc + `KCPU_AW'd2;
        end else if (sbranch && !bdone) begin
            pc_next = pc + offset8;
        end else if (lbranch && !bdone) begin
            pc_next = pc + mdata;
        end else if (up_pc) begin
            pc_next = mdata;
        end
        // a pulled PC byte wins over everything above.
        if (up_pul_pc && pul_en) begin
            if (hihalf)
                pc_next[15:8] = mdata[7:0];
            else
                pc_next[7:0] = mdata[7:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc    <= '0;
            pcbad <= '0;
            bdone <= 1'b0;
        end else if (cen) begin
            pc    <= pc_next;
            // held requests add the offset once.
            bdone <= sbranch | lbranch;
            if (buserror)
                pcbad <= pc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/kcpu_regwe.sv
`default_nettype none

module kcpu_regwe (
    input  logic [7:0] op,
    input  logic       up_ld8,
    input  logic       up_ld16,
    input  logic       up_lea,
    input  logic       up_lda,
    input  logic       up_ldb,
    input  logic       up_ab,
    input  logic       up_lmul,
    input  logic       up_div,
    output logic       up_a,
    output logic       up_b,
    output logic       up_d,
    output logic       up_x,
    output logic       up_y,
    output logic       up_u,
    output logic       up_s
);

    logic [2:0] r16;
    logic [1:0] lea_tgt;

    // 16-bit load target in the order D X Y U S.
    assign r16     = op[3:1];
    assign lea_tgt = op[1:0];

    // 8-bit loads pick the accumulator by op bit 0.
    assign up_a = (up_ld8 & ~op[0]) | up_lda;
    assign up_b = (up_ld8 & op[0]) | up_ldb | up_div;

    assign up_d = (up_ld16 && r16 == 3'd0) || up_ab;

    // multiply writes X and Y, divide writes B and X.
    assign up_x = (up_ld16 && r16 == 3'd1) || (up_lea && lea_tgt == kcpu_pkg::LEAX)
                  || up_lmul || up_div;
    assign up_y = (up_ld16 && r16 == 3'd2) || (up_lea && lea_tgt == kcpu_pkg::LEAY)
                  || up_lmul;
    assign up_u = (up_ld16 && r16 == 3'd3) || (up_lea && lea_tgt == kcpu_pkg::LEAU);
    assign up_s = (up_ld16 && r16 == 3'd4) || (up_lea && lea_tgt == kcpu_pkg::LEAS);

endmodule

`default_nettype wire

//--- rtl/kcpu_ctrl.sv
`default_nettype none

`include "kcpu_defs.svh"

module kcpu_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic [7:0]             op,
    input  logic [7:0]             cc,
    input  logic [`KCPU_DW-1:0]    mdata,
    input  logic [`KCPU_AW-1:0]    idx_addr,
    input  logic                   mem_busy,
    input  logic                   pc_step,
    input  logic                   pc_inc2,
    input  logic                   pc_jmp,
    input  logic                   up_pc,
    input  logic                   set_pc_branch8,
    input  logic                   set_pc_branch16,
    input  logic                   branch_bnz,
    input  logic                   psh_go,
    input  logic                   pul_go,
    input  logic                   psh_pc,
    input  logic                   up_pul_pc,
    input  logic                   up_ld8,
    input  logic                   up_ld16,
    input  logic                   up_lea,
    input  logic                   up_lda,
    input  logic                   up_ldb,
    input  logic                   up_ab,
    input  logic                   up_lmul,
    input  logic                   up_div,
    input  logic                   buserror,
    output logic [`KCPU_AW-1:0]    pc,
    output logic [`KCPU_AW-1:0]    pcbad,
    output logic [`KCPU_MASKW-1:0] psh_sel,
    output logic                   psh_dec,
    output logic                   stack_busy,
    output logic                   up_a,
    output logic                   up_b,
    output logic                   up_d,
    output logic                   up_x,
    output logic                   up_y,
    output logic                   up_u,
    output logic                   up_s
);

    logic branch;
    logic hihalf;
    logic pul_en;

    kcpu_branch kcpu_branch_inst (
        .op     (op),
        .cc     (cc),
        .branch (branch)
    );

    // postbyte comes in on the low data byte.
    kcpu_pshpul kcpu_pshpul_inst (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .mem_busy (mem_busy),
        .psh_go   (psh_go),
        .pul_go   (pul_go),
        .psh_pc   (psh_pc),
        .postdata (mdata[`KCPU_MASKW-1:0]),
        .psh_sel  (psh_sel),
        .hihalf   (hihalf),
        .pul_en   (pul_en),
        .psh_dec  (psh_dec),
        .busy     (stack_busy)
    );

    kcpu_pc kcpu_pc_inst (
        .clk             (clk),
        .rst             (rst),
        .cen             (cen),
        .pc_jmp          (pc_jmp),
        .pc_step         (pc_step),
        .pc_inc2         (pc_inc2),
        .up_pc           (up_pc),
        .set_pc_branch8  (set_pc_branch8),
        .set_pc_branch16 (set_pc_branch16),
        .branch_bnz      (branch_bnz),
        .branch          (branch),
        .up_pul_pc       (up_pul_pc),
        .pul_en          (pul_en),
        .hihalf          (hihalf),
        .buserror        (buserror),
        .cc              (cc),
        .mdata           (mdata),
        .idx_addr        (idx_addr),
        .pc              (pc),
        .pcbad           (pcbad)
    );

    kcpu_regwe kcpu_regwe_inst (
        .op      (op),
        .up_ld8  (up_ld8),
        .up_ld16 (up_ld16),
        .up_lea  (up_lea),
        .up_lda  (up_lda),
        .up_ldb  (up_ldb),
        .up_ab   (up_ab),
        .up_lmul (up_lmul),
        .up_div  (up_div),
        .up_a    (up_a),
        .up_b    (up_b),
        .up_d    (up_d),
        .up_x    (up_x),
        .up_y    (up_y),
        .up_u    (up_u),
        .up_s    (up_s)
    );

endmodule

`default_nettype wire

//--- verification/tb_kcpu_ctrl.sv
`default_nettype none

`include "kcpu_defs.svh"

module tb_kcpu_ctrl;

    localparam int N_BRANCH = 100;
    localparam int N_PRIO   = 300;
    localparam int N_ONCE   = 10;
    localparam int N_PUSH   = 20;
    localparam int N_PULL   = 10;
    localparam int N_REGWE  = 200;
    // reset, idle cycles between tests and a safety margin.
    localparam int MAX_CYCLES = 48 + 3 * N_BRANCH + N_PRIO + 12 * N_ONCE
                                + 64 * (N_PUSH + N_PULL) + N_REGWE + 200;

    // bit positions in the write-enable vector {a, b, d, x, y, u, s}.
    localparam int WE_A = 6;
    localparam int WE_B = 5;
    localparam int WE_D = 4;
    localparam int WE_X = 3;
    localparam int WE_Y = 2;
    localparam int WE_U = 1;
    localparam int WE_S = 0;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   cen;
    logic [7:0]             op;
    logic [7:0]             cc;
    logic [`KCPU_DW-1:0]    mdata;
    logic [`KCPU_AW-1:0]    idx_addr;
    logic                   mem_busy;
    logic                   pc_step;
    logic                   pc_inc2;
    logic                   pc_jmp;
    logic                   up_pc;
    logic                   set_pc_branch8;
    logic                   set_pc_branch16;
    logic                   branch_bnz;
    logic                   psh_go;
    logic                   pul_go;
    logic                   psh_pc;
    logic                   up_pul_pc;
    logic                   up_ld8;
    logic                   up_ld16;
    logic                   up_lea;
    logic                   up_lda;
    logic                   up_ldb;
    logic                   up_ab;
    logic                   up_lmul;
    logic                   up_div;
    logic                   buserror;
    logic [`KCPU_AW-1:0]    pc;
    logic [`KCPU_AW-1:0]    pcbad;
    logic [`KCPU_MASKW-1:0] psh_sel;
    logic                   psh_dec;
    logic                   stack_busy;
    logic                   up_a;
    logic                   up_b;
    logic                   up_d;
    logic                   up_x;
    logic                   up_y;
    logic                   up_u;
    logic                   up_s;

    logic [31:0] rng = 32'd72;
    int          checks = 0;
    int          value_errors = 0;
    int          seq_errors = 0;
    int          cycle_count = 0;

    // reference model state.
    logic [`KCPU_AW-1:0] m_pc;
    logic [`KCPU_AW-1:0] m_pcbad;
    logic                m_bdone;
    logic                m_busy;
    logic                m_pull;
    logic                m_hi;
    logic                m_dec;
    logic                m_pulen;
    logic [7:0]          m_sel;
    // one entry per stack byte as {high half, register bit}.
    logic [3:0]          byte_q[$];

    kcpu_ctrl kcpu_ctrl_inst (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic branch_taken(input logic [7:0] opc, input logic [7:0] ccr);
        logic c;
        logic v;
        logic z;
        logic n;
        logic base;
        c = ccr[kcpu_pkg::CC_C];
        v = ccr[kcpu_pkg::CC_V];
        z = ccr[kcpu_pkg::CC_Z];
        n = ccr[kcpu_pkg::CC_N];
        case (opc[3:1])
            3'd0:    base = 1'b1;
            3'd1:    base = !(c || z);
            3'd2:    base = !c;
            3'd3:    base = !z;
            3'd4:    base = !v;
            3'd5:    base = !n;
            3'd6:    base = !(n ^ v);
            default: base = !(z || (n ^ v));
        endcase
        // each odd code is the negation of the even one below it.
        return base ^ opc[0];
    endfunction

    function automatic logic [6:0] write_enables(input logic [7:0] opc, input logic ld8,
                                                 input logic ld16, input logic lea,
                                                 input logic lda, input logic ldb,
                                                 input logic ab, input logic lmul,
                                                 input logic div);
        logic [6:0] we;
        we = '0;
        if (ld8) begin
            if (opc[0])
                we[WE_B] = 1'b1;
            else
                we[WE_A] = 1'b1;
        end
        if (ld16) begin
            case (opc[3:1])
                3'd0:    we[WE_D] = 1'b1;
                3'd1:    we[WE_X] = 1'b1;
                3'd2:    we[WE_Y] = 1'b1;
                3'd3:    we[WE_U] = 1'b1;
                3'd4:    we[WE_S] = 1'b1;
                default: we = we;
            endcase
        end
        if (lea) begin
            case (opc[1:0])
                kcpu_pkg::LEAX: we[WE_X] = 1'b1;
                kcpu_pkg::LEAY: we[WE_Y] = 1'b1;
                kcpu_pkg::LEAU: we[WE_U] = 1'b1;
                default:        we[WE_S] = 1'b1;
            endcase
        end
        if (lmul) begin
            we[WE_X] = 1'b1;
            we[WE_Y] = 1'b1;
        end
        if (div) begin
            we[WE_B] = 1'b1;
            we[WE_X] = 1'b1;
        end
        if (ab)
            we[WE_D] = 1'b1;
        if (lda)
            we[WE_A] = 1'b1;
        if (ldb)
            we[WE_B] = 1'b1;
        return we;
    endfunction

    function automatic int stack_bytes(input logic [7:0] m);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            if (m[i])
                n += (i >= 4) ? 2 : 1;
        end
        return n;
    endfunction

    task automatic load_stack_queue(input logic pull, input logic [7:0] m);
        int j;
        byte_q.delete();
        for (int i = 0; i < 8; i++) begin
            j = pull ? i : 7 - i;
            if (m[j]) begin
                if (j >= 4) begin
                    // pull takes the high byte first, push the low byte.
                    byte_q.push_back({pull, 3'(j)});
                    byte_q.push_back({!pull, 3'(j)});
                end else begin
                    byte_q.push_back({1'b0, 3'(j)});
                end
            end
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            value_errors++;
            $display("Fail time=%0t signal=%s expected=%h got=%h", $time, name, exp, got);
        end
    endtask

    task automatic drive_idle();
        cen             <= 1'b1;
        mem_busy        <= 1'b0;
        pc_step         <= 1'b0;
        pc_inc2         <= 1'b0;
        pc_jmp          <= 1'b0;
        up_pc           <= 1'b0;
        set_pc_branch8  <= 1'b0;
        set_pc_branch16 <= 1'b0;
        branch_bnz      <= 1'b0;
        psh_go          <= 1'b0;
        pul_go          <= 1'b0;
        psh_pc          <= 1'b0;
        up_pul_pc       <= 1'b0;
        up_ld8          <= 1'b0;
        up_ld16         <= 1'b0;
        up_lea          <= 1'b0;
        up_lda          <= 1'b0;
        up_ldb          <= 1'b0;
        up_ab           <= 1'b0;
        up_lmul         <= 1'b0;
        up_div          <= 1'b0;
        buserror        <= 1'b0;
    endtask

    // one push or pull that counts the bytes the DUT accepts.
    task automatic run_stack(input logic pull, input logic [7:0] mask, input logic pcbit);
        int                  nbytes;
        int                  expect_n;
        logic                mb;
        logic                first;
        logic [31:0]         r;
        logic [`KCPU_AW-1:0] exp_pc;
        expect_n = stack_bytes(mask | {pcbit, 7'b0});
        nbytes   = 0;
        first    = 1'b1;
        @(posedge clk);
        cen       <= 1'b1;
        mem_busy  <= 1'b0;
        mdata     <= {8'h00, mask};
        psh_pc    <= pcbit;
        up_pul_pc <= pull;
        if (pull)
            pul_go <= 1'b1;
        else
            psh_go <= 1'b1;
        @(negedge clk);
        exp_pc = m_pc;
        @(posedge clk);
        psh_go   <= 1'b0;
        pul_go   <= 1'b0;
        psh_pc   <= 1'b0;
        r        = xorshift32();
        mb       = (r[1:0] == 2'b00);
        mem_busy <= mb;
        mdata    <= r[31:16];
        forever begin
            @(negedge clk);
            if (pull && m_pulen) begin
                if (m_hi)
                    exp_pc[15:8] = mdata[7:0];
                else
                    exp_pc[7:0] = mdata[7:0];
            end
            if (first) begin
                assert (stack_busy) else begin
                    seq_errors++;
                    $display("stack transfer did not start after the start pulse at %0t", $time);
                end
                first = 1'b0;
            end
            if (!stack_busy)
                break;
            // a step happens on the next edge unless memory holds it.
            if (!mb)
                nbytes++;
            @(posedge clk);
            r        = xorshift32();
            mb       = (r[1:0] == 2'b00);
            mem_busy <= mb;
            mdata    <= r[31:16];
        end
        check_value("byte_count", 16'(nbytes), 16'(expect_n));
        if (pull && pcbit)
            check_value("pc_after_pull", pc, exp_pc);
        @(posedge clk);
        drive_idle();
    endtask

    always @(posedge clk) begin : ref_model
        logic                sb;
        logic                lb;
        logic                start;
        logic [`KCPU_AW-1:0] nxt;
        logic [3:0]          ent;
        if (rst) begin
            m_pc    = '0;
            m_pcbad = '0;
            m_bdone = 1'b0;
            m_busy  = 1'b0;
            m_pull  = 1'b0;
            m_hi    = 1'b0;
            m_dec   = 1'b0;
            m_pulen = 1'b0;
            m_sel   = '0;
            byte_q.delete();
        end else if (cen) begin
            sb  = (set_pc_branch8 && branch_taken(op, cc))
                  || (branch_bnz && !cc[kcpu_pkg::CC_Z]);
            lb  = set_pc_branch16 && branch_taken(op, cc);
            nxt = m_pc;
            if (pc_jmp)
                nxt = idx_addr;
            else if (pc_step)
                nxt = m_pc + 16'd1;
            else if (pc_inc2)
                nxt = m_pc + 16'd2;
            else if (sb && !m_bdone)
                nxt = m_pc + {{8{mdata[7]}}, mdata[7:0]};
            else if (lb && !m_bdone)
                nxt = m_pc + mdata;
            else if (up_pc)
                nxt = mdata;
            if (up_pul_pc && m_pulen) begin
                if (m_hi)
                    nxt[15:8] = mdata[7:0];
                else
                    nxt[7:0] = mdata[7:0];
            end
            if (buserror)
                m_pcbad = m_pc;
            m_pc    = nxt;
            m_bdone = sb || lb;

            start = (psh_go || pul_go) && !m_busy;
            if (start) begin
                m_pull = pul_go;
                load_stack_queue(pul_go, mdata[7:0] | {psh_pc, 7'b0});
            end
            if (start || (m_busy && !mem_busy)) begin
                if (byte_q.size() > 0) begin
                    ent     = byte_q.pop_front();
                    m_busy  = 1'b1;
                    m_sel   = 8'b1 << ent[2:0];
                    m_hi    = ent[3];
                    m_dec   = !m_pull;
                    m_pulen = m_pull;
                end else begin
                    m_busy  = 1'b0;
                    m_sel   = '0;
                    m_hi    = 1'b0;
                    m_dec   = 1'b0;
                    m_pulen = 1'b0;
                end
            end
        end
    end

    // compare every cycle away from the driving edge.
    always @(negedge clk) begin
        if (!rst) begin
            check_value("pc", pc, m_pc);
            check_value("pcbad", pcbad, m_pcbad);
            check_value("psh_sel", 16'(psh_sel), 16'(m_sel));
            check_value("psh_dec", 16'(psh_dec), 16'(m_dec));
            check_value("stack_busy", 16'(stack_busy), 16'(m_busy));
            check_value("hihalf", 16'(kcpu_ctrl_inst.hihalf), 16'(m_hi));
            check_value("pul_en", 16'(kcpu_ctrl_inst.pul_en), 16'(m_pulen));
            check_value("write_enables", 16'({up_a, up_b, up_d, up_x, up_y, up_u, up_s}),
                        16'(write_enables(op, up_ld8, up_ld16, up_lea, up_lda, up_ldb,
                                          up_ab, up_lmul, up_div)));
        end
    end

    initial begin : watchdog
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles, the tests did not finish", cycle_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0]         r;
        logic [`KCPU_AW-1:0] pc0;
        logic [`KCPU_AW-1:0] exp;
        logic [`KCPU_DW-1:0] off;
        logic [7:0]          mask;
        int                  len;
        rst      = 1'b1;
        op       = '0;
        cc       = '0;
        mdata    = '0;
        idx_addr = '0;
        drive_idle();
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // short branches on random conditions.
        for (int i = 0; i < N_BRANCH; i++) begin
            @(negedge clk);
            pc0 = m_pc;
            @(posedge clk);
            r = xorshift32();
            op             <= r[7:0];
            cc             <= r[15:8];
            mdata          <= r[31:16];
            set_pc_branch8 <= 1'b1;
            exp = pc0;
            if (branch_taken(r[7:0], r[15:8]))
                exp = pc0 + {{8{r[23]}}, r[23:16]};
            @(posedge clk);
            set_pc_branch8 <= 1'b0;
            @(negedge clk);
            check_value("pc_after_branch8", pc, exp);
        end

        // pc update priority with cen gaps and decrement branches.
        for (int i = 0; i < N_PRIO; i++) begin
            @(posedge clk);
            r = xorshift32();
            cen        <= r[0] | r[1];
            pc_jmp     <= r[2] & r[3];
            pc_step    <= r[4];
            pc_inc2    <= r[5];
            up_pc      <= r[6];
            branch_bnz <= r[7] & r[8];
            cc         <= r[15:8];
            r = xorshift32();
            idx_addr <= r[15:0];
            mdata    <= r[31:16];
        end
        @(posedge clk);
        drive_idle();

        // long branch held several cycles and then a bus error.
        for (int i = 0; i < N_ONCE; i++) begin
            @(negedge clk);
            pc0 = m_pc;
            r   = xorshift32();
            off = r[15:0];
            len = 2 + int'(r[18:16] % 3'd5);
            @(posedge clk);
            op              <= 8'h20;
            mdata           <= off;
            set_pc_branch16 <= 1'b1;
            repeat (len) @(posedge clk);
            set_pc_branch16 <= 1'b0;
            @(negedge clk);
            check_value("pc_after_branch16", pc, pc0 + off);
            pc0 = m_pc;
            @(posedge clk);
            buserror <= 1'b1;
            pc_step  <= 1'b1;
            @(posedge clk);
            buserror <= 1'b0;
            pc_step  <= 1'b0;
            @(negedge clk);
            check_value("pcbad_after_buserror", pcbad, pc0);
        end

        for (int i = 0; i < N_PUSH; i++) begin
            r    = xorshift32();
            mask = r[7:0];
            if (mask == 8'h00 && !r[8])
                mask = 8'h01;
            run_stack(1'b0, mask, r[8]);
        end

        // pulls always reload the pc.
        for (int i = 0; i < N_PULL; i++) begin
            r = xorshift32();
            run_stack(1'b1, r[7:0], 1'b1);
        end

        for (int i = 0; i < N_REGWE; i++) begin
            @(posedge clk);
            r = xorshift32();
            op      <= r[7:0];
            up_ld8  <= r[8] & r[9];
            up_ld16 <= r[10] & r[11];
            up_lea  <= r[12] & r[13];
            up_lda  <= &r[16:14];
            up_ldb  <= &r[19:17];
            up_ab   <= &r[22:20];
            up_lmul <= &r[25:23];
            up_div  <= &r[28:26];
        end
        @(posedge clk);
        drive_idle();
        @(negedge clk);

        $display("checks %0d, value errors %0d, sequence errors %0d",
                 checks, value_errors, seq_errors);
        if (value_errors == 0 && seq_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
rtl/kcpu_pkg.sv
rtl/kcpu_branch.sv
rtl/kcpu_pshpul.sv
rtl/kcpu_pc.sv
rtl/kcpu_regwe.sv
rtl/kcpu_ctrl.sv
verification/tb_kcpu_ctrl.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_kcpu_ctrl

out=$(./obj_dir/Vtb_kcpu_ctrl)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED"
